/* verilog/fetch_pkg.sv */
// Shared types for the instruction fetch stage
// Addresses are byte addresses, instructions are half-word aligned
// Only the two low bits of a half-word are decoded, to tell 16 from 32 bit

package fetch_pkg;

  // Width of every fetch address in the stage
  localparam int unsigned FETCH_ADDR_W = 32;

  typedef logic [FETCH_ADDR_W-1:0] fetch_addr_t;

  // One fetched word split into its two half-words
  typedef struct packed {
    logic [15:0] hi;
    logic [15:0] lo;
  } instr_half_t;

  // Same 32 bits, read as a whole instruction or as two halves
  typedef union packed {
    logic [31:0] full;
    instr_half_t half;
  } instr_word_u;

  // Memory response as it arrives from the bus
  typedef struct packed {
    instr_word_u rdata;
    logic        err;
  } fetch_rsp_t;

  // One realigned instruction handed to the core
  typedef struct packed {
    fetch_addr_t addr;
    fetch_addr_t addr_next;
    instr_word_u rdata;
    logic        err;
    logic        err_plus2;   // only the second word of an unaligned instr failed
  } fetch_instr_t;

  // Compressed when the low two bits are not both set
  function automatic logic fetch_is_compressed(input logic [15:0] half);
    return half[1:0] != 2'b11;
  endfunction

endpackage

/* verilog/fetch_req_ctrl.sv */
// Issues word-aligned reads, at most NUM_REQS granted and unanswered
// Idle after reset until the first branch_i pulse
// Responses must come back in request order, one rvalid pulse each

module fetch_req_ctrl #(
  parameter int unsigned NUM_REQS = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // Branch from the core
  input  logic                    branch_i,
  input  fetch_pkg::fetch_addr_t  branch_addr_i,

  // Memory request side
  output logic                    mem_req_o,
  output fetch_pkg::fetch_addr_t  mem_addr_o,
  input  logic                    mem_gnt_i,
  input  logic                    mem_rvalid_i,
  input  fetch_pkg::fetch_rsp_t   mem_rsp_i,

  // FIFO side
  input  logic [NUM_REQS-1:0]     fifo_busy_i,
  output logic                    fifo_clear_o,
  output fetch_pkg::fetch_addr_t  fifo_addr_o,
  output logic                    fifo_valid_o,
  output fetch_pkg::fetch_rsp_t   fifo_rsp_o
);

  // Wide enough for outstanding plus busy entries
  localparam int unsigned CNT_W = $clog2(2 * NUM_REQS + 1);

  logic                   fetch_en_q;
  logic                   req_pend_q;
  fetch_pkg::fetch_addr_t fetch_addr_q;
  logic [CNT_W-1:0]       out_cnt_q, out_cnt_d;
  logic [CNT_W-1:0]       disc_cnt_q, disc_cnt_d;
  logic [CNT_W-1:0]       busy_cnt;
  logic [CNT_W-1:0]       load_cnt;
  logic                   budget_ok;
  logic                   gnt;
  logic                   discard;

  ////////////////////////////////////////////////////////////
  // Request budget
  ////////////////////////////////////////////////////////////

  // Number of upper FIFO entries in use
  always_comb begin
    busy_cnt = '0;
    for (int i = 0; i < NUM_REQS; i++) begin
      busy_cnt = busy_cnt + CNT_W'(fifo_busy_i[i]);
    end
  end

  // Every outstanding request may still land in the FIFO
  assign load_cnt  = out_cnt_q + busy_cnt;
  assign budget_ok = load_cnt < CNT_W'(NUM_REQS);

  // A pending request stays up until granted
  // In the branch cycle it is dropped and reissued at the target
  assign mem_req_o  = fetch_en_q & ~branch_i & (req_pend_q | budget_ok);
  assign mem_addr_o = fetch_addr_q;
  assign gnt        = mem_req_o & mem_gnt_i;

  ////////////////////////////////////////////////////////////
  // Outstanding and discard counters
  ////////////////////////////////////////////////////////////

  assign out_cnt_d = out_cnt_q + CNT_W'(gnt) - CNT_W'(mem_rvalid_i);

  // Responses still owed to the old stream
  assign discard = disc_cnt_q != '0;

  // At a branch all requests still in flight belong to the old stream
  assign disc_cnt_d = branch_i ? out_cnt_d :
                                 disc_cnt_q - CNT_W'(mem_rvalid_i & discard);

  ////////////////////////////////////////////////////////////
  // FIFO feed
  ////////////////////////////////////////////////////////////

  assign fifo_clear_o = branch_i;
  assign fifo_addr_o  = branch_addr_i;
  // Old-stream responses never reach the FIFO
  assign fifo_valid_o = mem_rvalid_i & ~discard;
  assign fifo_rsp_o   = discard ? '0 : mem_rsp_i;

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_en_q   <= 1'b0;
      req_pend_q   <= 1'b0;
      out_cnt_q    <= '0;
      disc_cnt_q   <= '0;
      fetch_addr_q <= '0;
    end else begin
      // Fetching starts at the first branch and never stops
      if (branch_i) begin
        fetch_en_q <= 1'b1;
      end
      req_pend_q <= mem_req_o & ~mem_gnt_i;
      out_cnt_q  <= out_cnt_d;
      disc_cnt_q <= disc_cnt_d;
      // Target rounded down to a word
      if (branch_i) begin
        fetch_addr_q <= {branch_addr_i[fetch_pkg::FETCH_ADDR_W-1:2], 2'b00};
      end else if (gnt) begin
        fetch_addr_q <= fetch_addr_q + fetch_pkg::fetch_addr_t'(4);
      end
    end
  end

endmodule

/* verilog/fetch_fifo.sv */
// Word FIFO of NUM_REQS+1 entries with a bypass from the input
// Realigns 16 and 32 bit instructions that may start mid-word
// clear_i empties the FIFO for the next cycle, input data included

module fetch_fifo #(
  parameter int unsigned NUM_REQS = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // Control
  input  logic                    clear_i,
  input  fetch_pkg::fetch_addr_t  in_addr_i,
  output logic [NUM_REQS-1:0]     busy_o,

  // Input from the request controller
  input  logic                    in_valid_i,
  input  fetch_pkg::fetch_rsp_t   in_rsp_i,

  // Output to the core
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output fetch_pkg::fetch_instr_t out_instr_o
);

  localparam int unsigned DEPTH = NUM_REQS + 1;

  // Entry 0 is the head
  fetch_pkg::fetch_rsp_t [DEPTH-1:0] rsp_d, rsp_q;
  logic [DEPTH-1:0]                  valid_d, valid_q;
  logic [DEPTH-1:0]                  lowest_free;
  logic [DEPTH-1:0]                  valid_pushed, valid_popped;
  logic [DEPTH-1:0]                  entry_en;

  fetch_pkg::fetch_rsp_t  head, second;
  fetch_pkg::instr_word_u rdata_unaligned;
  logic                   err_unaligned, err_plus2;
  logic                   valid, valid_unaligned, out_valid;
  logic                   aligned_is_compressed, unaligned_is_compressed;
  logic                   pop_fifo;

  logic                   addr_incr_two;
  logic                   instr_addr_en;
  fetch_pkg::fetch_addr_t instr_addr_q, instr_addr_d, instr_addr_next;

  ////////////////////////////////////////////////////////////
  // Head word and bypass
  ////////////////////////////////////////////////////////////

  // Empty FIFO shows the incoming word directly
  assign head   = valid_q[0] ? rsp_q[0] : in_rsp_i;
  assign valid  = valid_q[0] | in_valid_i;
  // Word after the head, from entry 1 or from the input
  assign second = valid_q[1] ? rsp_q[1] : in_rsp_i;

  // Length decode on the half that starts the instruction
  // Error words carry no usable data
  assign aligned_is_compressed   =
      fetch_pkg::fetch_is_compressed(head.rdata.half.lo) & ~head.err;
  assign unaligned_is_compressed =
      fetch_pkg::fetch_is_compressed(head.rdata.half.hi) | head.err;

  ////////////////////////////////////////////////////////////
  // Realigner
  ////////////////////////////////////////////////////////////

  // Upper half of head joined with lower half of the next word
  assign rdata_unaligned.half.lo = head.rdata.half.hi;
  assign rdata_unaligned.half.hi = second.rdata.half.lo;

  // Second word only counts for a 32 bit instr
  // With entry 0 empty the head is the input word itself
  assign err_unaligned = valid_q[1] ?
      (rsp_q[0].err | (rsp_q[1].err & ~unaligned_is_compressed)) :
      ((valid_q[0] & rsp_q[0].err) |
       (in_rsp_i.err & (~valid_q[0] | ~unaligned_is_compressed)));

  // Only meaningful together with err_unaligned
  assign err_plus2 = valid_q[1] ? (rsp_q[1].err & ~rsp_q[0].err) :
                                  (in_rsp_i.err & valid_q[0] & ~rsp_q[0].err);

  // Both words must be present for a split 32 bit instr
  assign valid_unaligned = valid_q[1] | (valid_q[0] & in_valid_i);

  always_comb begin
    out_instr_o.addr      = instr_addr_q;
    out_instr_o.addr_next = instr_addr_next;
    if (instr_addr_q[1]) begin
      out_instr_o.rdata     = rdata_unaligned;
      out_instr_o.err       = err_unaligned;
      out_instr_o.err_plus2 = err_plus2;
      out_valid             = unaligned_is_compressed ? valid : valid_unaligned;
    end else begin
      out_instr_o.rdata     = head.rdata;
      out_instr_o.err       = head.err;
      out_instr_o.err_plus2 = 1'b0;
      out_valid             = valid;
    end
  end

  assign out_valid_o = out_valid;

  ////////////////////////////////////////////////////////////
  // Instruction address
  ////////////////////////////////////////////////////////////

  assign instr_addr_en = clear_i | (out_ready_i & out_valid);

  assign addr_incr_two   = instr_addr_q[1] ? unaligned_is_compressed :
                                             aligned_is_compressed;
  assign instr_addr_next = instr_addr_q + (addr_incr_two ? fetch_pkg::fetch_addr_t'(2) :
                                                           fetch_pkg::fetch_addr_t'(4));

  // Bit 0 is forced low, targets are half-word aligned
  assign instr_addr_d = clear_i ? {in_addr_i[fetch_pkg::FETCH_ADDR_W-1:1], 1'b0} :
                                  instr_addr_next;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_addr_q <= '0;
    end else if (instr_addr_en) begin
      instr_addr_q <= instr_addr_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // FIFO control
  ////////////////////////////////////////////////////////////

  // Upper entries tell the controller how much room is left
  assign busy_o = valid_q[DEPTH-1:DEPTH-NUM_REQS];

  // Head leaves once its last half-word is taken
  assign pop_fifo = out_ready_i & out_valid & (~aligned_is_compressed | instr_addr_q[1]);

  for (genvar i = 0; i < DEPTH; i++) begin : g_entry
    // Write pointer is the lowest empty entry
    if (i == 0) begin : g_head
      assign lowest_free[i] = ~valid_q[i];
    end else begin : g_rest
      assign lowest_free[i] = ~valid_q[i] & valid_q[i-1];
    end

    assign valid_pushed[i] = valid_q[i] | (in_valid_i & lowest_free[i]);

    if (i < DEPTH - 1) begin : g_shift
      // Pop shifts everything down by one
      assign valid_popped[i] = pop_fifo ? valid_pushed[i+1] : valid_pushed[i];
      assign entry_en[i]     = (pop_fifo & valid_pushed[i+1]) |
                               (~pop_fifo & in_valid_i & lowest_free[i]);
      assign rsp_d[i]        = valid_q[i+1] ? rsp_q[i+1] : in_rsp_i;
    end else begin : g_top
      // Top entry only ever takes new input
      assign valid_popped[i] = ~pop_fifo & valid_pushed[i];
      assign entry_en[i]     = in_valid_i & lowest_free[i];
      assign rsp_d[i]        = in_rsp_i;
    end

    assign valid_d[i] = valid_popped[i] & ~clear_i;

    // Payload register, no reset
    always_ff @(posedge clk_i) begin
      if (entry_en[i]) begin
        rsp_q[i] <= rsp_d[i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

endmodule

/* verilog/fetch_top.sv */
// Instruction fetch stage, request controller plus realigning FIFO
// branch_addr_i must be half-word aligned
// Fetching begins at the first branch_i pulse after reset

module fetch_top #(
  parameter int unsigned NUM_REQS = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // Core side
  input  logic                    branch_i,
  input  fetch_pkg::fetch_addr_t  branch_addr_i,
  output logic                    instr_valid_o,
  input  logic                    instr_ready_i,
  output fetch_pkg::fetch_instr_t instr_o,

  // Memory side
  output logic                    mem_req_o,
  output fetch_pkg::fetch_addr_t  mem_addr_o,
  input  logic                    mem_gnt_i,
  input  logic                    mem_rvalid_i,
  input  fetch_pkg::fetch_rsp_t   mem_rsp_i
);

  logic                   fifo_clear;
  logic                   fifo_valid;
  fetch_pkg::fetch_rsp_t  fifo_rsp;
  fetch_pkg::fetch_addr_t fifo_addr;
  logic [NUM_REQS-1:0]    fifo_busy;

  // Bus requests, outstanding count and branch discards
  fetch_req_ctrl #(
    .NUM_REQS (NUM_REQS)
  ) u_req_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_gnt_i     (mem_gnt_i),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rsp_i     (mem_rsp_i),
    .fifo_busy_i   (fifo_busy),
    .fifo_clear_o  (fifo_clear),
    .fifo_addr_o   (fifo_addr),
    .fifo_valid_o  (fifo_valid),
    .fifo_rsp_o    (fifo_rsp)
  );

  // Word storage and instruction realignment
  fetch_fifo #(
    .NUM_REQS (NUM_REQS)
  ) u_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (fifo_clear),
    .in_addr_i   (fifo_addr),
    .busy_o      (fifo_busy),
    .in_valid_i  (fifo_valid),
    .in_rsp_i    (fifo_rsp),
    .out_valid_o (instr_valid_o),
    .out_ready_i (instr_ready_i),
    .out_instr_o (instr_o)
  );

endmodule

/* tests/fetch_mem_image.svh */
// Instruction memory image, included inside a module
// Below 0x100 all 32 bit, 0x100 to 0x1ff all compressed, above that mixed
// One word answers with an error, its data reads as zero

// Word that returns err
localparam logic [31:0] ERR_WORD_ADDR = 32'h0000_00c0;

// Half-word at a half-aligned byte address
function automatic logic [15:0] mem_half(input logic [31:0] a);
  logic [1:0] kind;
  if (a < 32'h0000_0100) begin
    kind = 2'b11;
  end else if (a < 32'h0000_0200) begin
    kind = 2'b01;
  end else begin
    // Mixed region, roughly half of the halves start a 32 bit instr
    kind = (a[2] ^ a[4] ^ a[5]) ? 2'b11 : {a[3], 1'b0};
  end
  return {a[31:18] ^ a[17:4] ^ {a[3:1], 11'h2a5}, kind};
endfunction

// True for any byte address inside the error word
function automatic logic mem_word_err(input logic [31:0] a);
  return {a[31:2], 2'b00} == ERR_WORD_ADDR;
endfunction

/* tests/fetch_mem_model.sv */
// Instruction memory responder, answers in request order
// Grant after 0 to 3 cycles of request, rvalid 1 to 4 cycles after grant
// At most one response per cycle

module fetch_mem_model (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  fetch_pkg::fetch_addr_t addr_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output fetch_pkg::fetch_rsp_t  rsp_o
);
  timeunit 1ns;
  timeprecision 1ps;

  `include "fetch_mem_image.svh"

  logic [1:0]             gnt_wait_q;
  int unsigned            cycle_q;
  int unsigned            due;
  int unsigned            last_due;
  fetch_pkg::fetch_addr_t addr_fifo[$];
  int unsigned            due_fifo[$];
  fetch_pkg::fetch_addr_t rsp_addr;

  // Grant comes up once the wait counter has run out
  assign gnt_o = gnt_wait_q == 2'd0;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_wait_q <= 2'd0;
      cycle_q    <= 0;
      rvalid_o   <= 1'b0;
      rsp_o      <= '0;
      last_due   = 0;
      addr_fifo.delete();
      due_fifo.delete();
    end else begin
      cycle_q <= cycle_q + 1;
      if (req_i && gnt_o) begin
        // Keep responses strictly ordered and one per cycle
        due = cycle_q + $urandom_range(4, 1) - 1;
        if (due <= last_due && due_fifo.size() > 0) begin
          due = last_due + 1;
        end
        last_due = due;
        addr_fifo.push_back(addr_i);
        due_fifo.push_back(due);
        gnt_wait_q <= 2'($urandom_range(3, 0));
      end else if (req_i && gnt_wait_q != 2'd0) begin
        gnt_wait_q <= gnt_wait_q - 2'd1;
      end
      rvalid_o <= 1'b0;
      if (due_fifo.size() > 0 && due_fifo[0] <= cycle_q) begin
        rsp_addr = addr_fifo.pop_front();
        void'(due_fifo.pop_front());
        rvalid_o  <= 1'b1;
        rsp_o.err <= mem_word_err(rsp_addr);
        rsp_o.rdata.full <= mem_word_err(rsp_addr) ? 32'h0 :
            {mem_half(rsp_addr + 32'd2), mem_half(rsp_addr)};
      end
    end
  end

endmodule

/* tests/fetch_tb.sv */
// Fetch stage testbench with NUM_REQS of 2 against a random latency memory
// The reference walker follows the memory image from each branch target
// After an instruction with err the walker halts until the next branch

module fetch_tb;
  timeunit 1ns;
  timeprecision 1ps;

  `include "fetch_mem_image.svh"

  localparam int unsigned NUM_REQS   = 2;
  localparam int unsigned WAIT_LIMIT = 2000;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    branch, instr_valid, instr_ready, stall_mode;
  logic                    mem_req, mem_gnt, mem_rvalid;
  fetch_pkg::fetch_addr_t  branch_addr, mem_addr;
  fetch_pkg::fetch_instr_t instr;
  fetch_pkg::fetch_rsp_t   mem_rsp;

  // Walker state and expected values
  fetch_pkg::fetch_addr_t  exp_addr, exp_next;
  logic [31:0]             exp_data;
  logic                    start_err, exp_len4, exp_err, exp_plus2;
  logic                    halted, accept, check;
  int                      n_acc, n_err, outstanding;

  always #50 clk_i = ~clk_i;

  fetch_top #(
    .NUM_REQS (NUM_REQS)
  ) dut0 (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .instr_valid_o (instr_valid),
    .instr_ready_i (instr_ready),
    .instr_o       (instr),
    .mem_req_o     (mem_req),
    .mem_addr_o    (mem_addr),
    .mem_gnt_i     (mem_gnt),
    .mem_rvalid_i  (mem_rvalid),
    .mem_rsp_i     (mem_rsp)
  );

  fetch_mem_model u_mem (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (mem_req),
    .addr_i   (mem_addr),
    .gnt_o    (mem_gnt),
    .rvalid_o (mem_rvalid),
    .rsp_o    (mem_rsp)
  );

  ////////////////////////////////////////////////////////////
  // Reference walker
  ////////////////////////////////////////////////////////////

  always_comb begin
    start_err = mem_word_err(exp_addr);
    exp_len4  = !fetch_pkg::fetch_is_compressed(mem_half(exp_addr));
    exp_err   = start_err | (exp_len4 & mem_word_err(exp_addr + 32'd2));
    // Only an unaligned 32 bit instr reaches into the next word
    exp_plus2 = !start_err & exp_len4 & exp_addr[1] & mem_word_err(exp_addr + 32'd2);
    exp_next  = exp_addr + (exp_len4 ? 32'd4 : 32'd2);
    exp_data  = {mem_half(exp_addr + 32'd2), mem_half(exp_addr)};
  end

  assign accept = instr_valid & instr_ready;
  assign check  = accept & ~halted;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exp_addr    <= '0;
      halted      <= 1'b1;
      n_acc       <= 0;
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(mem_req & mem_gnt) - int'(mem_rvalid);
      if (accept) begin
        n_acc <= n_acc + 1;
      end
      if (branch) begin
        exp_addr <= {branch_addr[31:1], 1'b0};
        halted   <= 1'b0;
      end else if (check) begin
        exp_addr <= exp_next;
        halted   <= exp_err;
      end
    end
  end

  // Random ready that stays mostly low in stall mode
  always @(posedge clk_i) begin
    instr_ready <= stall_mode ? ($urandom_range(15, 0) == 0) : ($urandom_range(1, 0) == 1);
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic note_mismatch(input string msg);
    $display("Fail %0t: %s", $time, msg);
    n_err++;
  endtask

  a_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
      check |-> instr.addr == exp_addr)
    else note_mismatch($sformatf("addr %h, expected %h", $sampled(instr.addr),
                                 $sampled(exp_addr)));

  a_next: assert property (@(posedge clk_i) disable iff (!rst_ni)
      check && !exp_err |-> instr.addr_next == exp_next)
    else note_mismatch($sformatf("addr_next wrong at %h", $sampled(exp_addr)));

  // Upper half of a compressed instr is don't care
  a_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
      check && !exp_err |-> (exp_len4 ? instr.rdata.full == exp_data :
                                        instr.rdata.half.lo == exp_data[15:0]))
    else note_mismatch($sformatf("rdata wrong at %h", $sampled(exp_addr)));

  a_err: assert property (@(posedge clk_i) disable iff (!rst_ni)
      check |-> instr.err == exp_err && (!exp_err || instr.err_plus2 == exp_plus2))
    else note_mismatch($sformatf("err flags wrong at %h", $sampled(exp_addr)));

  // Upper half counts only for a 32 bit instr
  // err_plus2 counts only together with err
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_valid && !instr_ready && !branch |=> instr_valid &&
      $stable(instr.addr) && $stable(instr.addr_next) && $stable(instr.err) &&
      $stable(instr.rdata.half.lo) &&
      (fetch_pkg::fetch_is_compressed(instr.rdata.half.lo) ||
       $stable(instr.rdata.half.hi)) &&
      (!instr.err || $stable(instr.err_plus2)))
    else note_mismatch("instruction changed while stalled");

  a_budget: assert property (@(posedge clk_i) disable iff (!rst_ni)
      outstanding <= NUM_REQS)
    else note_mismatch($sformatf("%0d requests outstanding", $sampled(outstanding)));

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Called on a rising edge and returns one edge later
  task automatic do_branch(input fetch_pkg::fetch_addr_t target);
    branch      <= 1'b1;
    branch_addr <= target;
    @(posedge clk_i);
    branch      <= 1'b0;
  endtask

  task automatic wait_accepts(input int n);
    int start;
    int cycles;
    start  = n_acc;
    cycles = 0;
    while (n_acc - start < n && cycles < WAIT_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    if (n_acc - start < n) begin
      $display("Timeout: only %0d of %0d instructions arrived", n_acc - start, n);
      n_err++;
    end
  endtask

  // Walker clears halted one edge after the branch
  task automatic wait_error_instr();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
    end while (!halted && cycles < WAIT_LIMIT);
    if (!halted) begin
      $display("Timeout: no instruction with err arrived");
      n_err++;
    end
  endtask

  task automatic wait_grant();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
    end while (!(mem_req && mem_gnt) && cycles < WAIT_LIMIT);
    if (!(mem_req && mem_gnt)) begin
      $display("Timeout: memory never granted a request");
      n_err++;
    end
  endtask

  task automatic end_test(input string name);
    $display("Test %s finished, %0d errors so far", name, n_err);
  endtask

  initial begin
    void'($urandom(32'ha7cbc6f2));
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    instr_ready = 1'b0;
    stall_mode  = 1'b0;
    n_err       = 0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    do_branch(32'h0000_0040);
    wait_accepts(12);
    end_test("aligned");

    do_branch(32'h0000_0100);
    wait_accepts(16);
    end_test("compressed");

    // Every instr here spans two words
    do_branch(32'h0000_0042);
    wait_accepts(10);
    end_test("unaligned");

    do_branch(32'h0000_0300);
    wait_grant();
    do_branch(32'h0000_020a);
    wait_accepts(20);
    wait_grant();
    do_branch(32'h0000_01fe);
    wait_accepts(12);
    end_test("branch in flight");

    // Error word hit by an aligned instr, a split one and one starting inside it
    do_branch(32'h0000_00b0);
    wait_error_instr();
    do_branch(32'h0000_00b2);
    wait_error_instr();
    do_branch(32'h0000_00c2);
    wait_error_instr();
    end_test("bus error");

    stall_mode <= 1'b1;
    do_branch(32'h0000_01f0);
    wait_accepts(16);
    stall_mode <= 1'b0;
    end_test("stall");

    $display("%0d instructions accepted, %0d errors", n_acc, n_err);
    if (n_err == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+tests
verilog/fetch_pkg.sv
verilog/fetch_req_ctrl.sv
verilog/fetch_fifo.sv
verilog/fetch_top.sv
tests/fetch_mem_model.sv
tests/fetch_tb.sv
